// ==== Bender.yml ====
package:
  name: word_mem

sources:
  - source/mem_geom_pkg.sv
  - source/mem_op_pkg.sv
  - source/store_align.sv
  - source/load_align.sv
  - source/amo_alu.sv
  - source/mem_engine.sv
  - source/word_mem_top.sv
  - target: test
    files:
      - bench/shadow_checker.sv
      - bench/tb_word_mem.sv

// ==== bench/shadow_checker.sv ====
`timescale 1ns/1ps

module shadow_checker
  import mem_geom_pkg::*;
  import mem_op_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  mem_opcode_e           opcode_i,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  logic [DATA_WIDTH-1:0] data_i,
  input  logic [MASK_WIDTH-1:0] mask_i,
  input  logic                  v_i,
  input  logic                  ready_i,
  input  logic [DATA_WIDTH-1:0] resp_data_i,
  input  logic                  resp_v_i,
  input  logic                  yumi_i,
  input  logic [DATA_WIDTH-1:0] exp_data_i,
  input  logic                  exp_v_i,
  output int                    pass_o,
  output int                    fail_o,
  output int                    resp_count_o
);

  logic [DATA_WIDTH-1:0] model [MEM_WORDS];
  logic [DATA_WIDTH-1:0] exp_q [$];
  logic                  hold_q;
  logic [DATA_WIDTH-1:0] hold_data;
  logic                  seen_accept;
  engine_state_e         idle_state;

  function automatic logic [DATA_WIDTH-1:0] load_value(input mem_opcode_e op,
      input logic [1:0] lo, input logic [MASK_WIDTH-1:0] m, input logic [DATA_WIDTH-1:0] w);
    logic [7:0]            b;
    logic [15:0]           h;
    logic [DATA_WIDTH-1:0] r;
    b = 8'(w >> (8 * lo));
    h = lo[1] ? w[31:16] : w[15:0];
    r = '0;
    case (op)
      LW:  r = w;
      LH:  r = {{16{h[15]}}, h};
      LHU: r = {16'h0, h};
      LB:  r = {{24{b[7]}}, b};
      LBU: r = {24'h0, b};
      LM: begin
        for (int i = 0; i < MASK_WIDTH; i++) begin
          r[8*i +: 8] = m[i] ? w[8*i +: 8] : 8'h00;
        end
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] store_value(input mem_opcode_e op,
      input logic [1:0] lo, input logic [DATA_WIDTH-1:0] d, input logic [MASK_WIDTH-1:0] m,
      input logic [DATA_WIDTH-1:0] w);
    logic [DATA_WIDTH-1:0] r;
    r = w;
    case (op)
      SW: r = d;
      SH: begin
        if (lo[1]) begin
          r[31:16] = d[15:0];
        end else begin
          r[15:0] = d[15:0];
        end
      end
      SB: r[8*lo +: 8] = d[7:0];
      SM: begin
        for (int i = 0; i < MASK_WIDTH; i++) begin
          if (m[i]) begin
            r[8*i +: 8] = d[8*i +: 8];
          end
        end
      end
      default: r = w;
    endcase
    return r;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] amo_value(input mem_opcode_e op,
      input logic [DATA_WIDTH-1:0] d, input logic [DATA_WIDTH-1:0] old);
    case (op)
      AMOSWAP_W: return d;
      AMOADD_W:  return d + old;
      AMOXOR_W:  return d ^ old;
      AMOAND_W:  return d & old;
      AMOOR_W:   return d | old;
      AMOMIN_W:  return ($signed(d) < $signed(old)) ? d : old;
      AMOMAX_W:  return ($signed(d) > $signed(old)) ? d : old;
      AMOMINU_W: return (d < old) ? d : old;
      AMOMAXU_W: return (d > old) ? d : old;
      default:   return old;
    endcase
  endfunction

  always @(posedge clk_i) begin : watch
    logic [DATA_WIDTH-1:0] expected;
    int                    widx;
    int                    base;
    if (reset_i) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        model[i] = '0;
      end
      exp_q.delete();
      hold_q = 1'b0;
      seen_accept = 1'b0;
      idle_state = ENG_IDLE;
      pass_o = 0;
      fail_o = 0;
      resp_count_o = 0;
    end else begin
      // a waiting response must not move
      if (hold_q && (!resp_v_i || resp_data_i !== hold_data)) begin
        $display("Mismatch at %0t: waiting response changed from %h to %h (valid %b)",
                 $time, hold_data, resp_data_i, resp_v_i);
        fail_o++;
      end
      if (resp_v_i && !seen_accept) begin
        $display("response valid at %0t before any request was accepted, engine should be %s",
                 $time, idle_state.name());
        fail_o++;
        seen_accept = 1'b1;
      end
      if (resp_v_i && yumi_i) begin
        resp_count_o++;
        if (exp_q.size() == 0) begin
          $display("response %h at %0t arrived with no request outstanding",
                   resp_data_i, $time);
          fail_o++;
        end else begin
          expected = exp_q.pop_front();
          if (resp_data_i !== expected) begin
            $display("Mismatch at %0t: test %0d returned %h, expected %h",
                     $time, resp_count_o, resp_data_i, expected);
            fail_o++;
          end else begin
            $display("test %0d ok, data %h", resp_count_o, resp_data_i);
            pass_o++;
          end
        end
      end
      if (v_i && ready_i) begin
        seen_accept = 1'b1;
        widx = int'(addr_i[ADDR_WIDTH-1:2]);
        case (opcode_i)
          LW, LH, LB, LHU, LBU, LM: begin
            expected = load_value(opcode_i, addr_i[1:0], mask_i, model[widx]);
          end
          SW, SH, SB, SM: begin
            model[widx] = store_value(opcode_i, addr_i[1:0], data_i, mask_i, model[widx]);
            expected = '0;
          end
          AALLOCZ: begin
            base = widx - (widx % BLOCK_WORDS);
            for (int i = 0; i < BLOCK_WORDS; i++) begin
              model[base + i] = '0;
            end
            expected = '0;
          end
          default: begin
            expected = model[widx];
            model[widx] = amo_value(opcode_i, data_i, model[widx]);
          end
        endcase
        if (exp_v_i && exp_data_i !== expected) begin
          $display("table value %h disagrees with model value %h at %0t",
                   exp_data_i, expected, $time);
          fail_o++;
        end
        exp_q.push_back(exp_v_i ? exp_data_i : expected);
      end
      hold_q = resp_v_i && !yumi_i;
      hold_data = resp_data_i;
    end
  end

endmodule

// ==== bench/tb_word_mem.sv ====
`timescale 1ns/1ps

module tb_word_mem
  import mem_geom_pkg::*;
  import mem_op_pkg::*;
();

  localparam int NUM_ROWS = 37;
  localparam int NUM_RANDOM = 200;
  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 8;
  // each request gets room for a full block fill plus a few stalled cycles
  localparam int WATCHDOG_NS = (NUM_ROWS + NUM_RANDOM) * (BLOCK_WORDS + 4) * 80
                               + RESET_CYCLES * CLK_PERIOD;

  logic                  clk_i;
  logic                  reset_i;
  mem_opcode_e           opcode_i;
  logic [ADDR_WIDTH-1:0] addr_i;
  logic [DATA_WIDTH-1:0] data_i;
  logic [MASK_WIDTH-1:0] mask_i;
  logic                  v_i;
  logic                  ready_o;
  logic [DATA_WIDTH-1:0] data_o;
  logic                  v_o;
  logic                  yumi_i;
  logic [DATA_WIDTH-1:0] exp_data;
  logic                  exp_v;
  int                    pass_count;
  int                    fail_count;
  int                    resp_count;

  mem_opcode_e           row_op   [NUM_ROWS];
  logic [ADDR_WIDTH-1:0] row_addr [NUM_ROWS];
  logic [DATA_WIDTH-1:0] row_data [NUM_ROWS];
  logic [MASK_WIDTH-1:0] row_mask [NUM_ROWS];
  logic [DATA_WIDTH-1:0] row_exp  [NUM_ROWS];
  int                    row_count;
  int                    sent;
  integer                seed;
  integer                yumi_seed;
  mem_opcode_e           op;
  logic [ADDR_WIDTH-1:0] addr;
  logic [DATA_WIDTH-1:0] data;
  logic [MASK_WIDTH-1:0] mask;

  word_mem_top word_mem_top_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .opcode_i (opcode_i),
    .addr_i   (addr_i),
    .data_i   (data_i),
    .mask_i   (mask_i),
    .v_i      (v_i),
    .ready_o  (ready_o),
    .data_o   (data_o),
    .v_o      (v_o),
    .yumi_i   (yumi_i)
  );

  shadow_checker checker_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .opcode_i     (opcode_i),
    .addr_i       (addr_i),
    .data_i       (data_i),
    .mask_i       (mask_i),
    .v_i          (v_i),
    .ready_i      (ready_o),
    .resp_data_i  (data_o),
    .resp_v_i     (v_o),
    .yumi_i       (yumi_i),
    .exp_data_i   (exp_data),
    .exp_v_i      (exp_v),
    .pass_o       (pass_count),
    .fail_o       (fail_count),
    .resp_count_o (resp_count)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // random back-pressure on the response side
  initial begin
    yumi_seed = 52;
    yumi_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #2;
      yumi_i = v_o && !reset_i && (($random(yumi_seed) & 3) != 0);
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, responses still missing", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  task automatic add_row(input mem_opcode_e r_op, input logic [ADDR_WIDTH-1:0] r_addr,
      input logic [DATA_WIDTH-1:0] r_data, input logic [MASK_WIDTH-1:0] r_mask,
      input logic [DATA_WIDTH-1:0] r_exp);
    row_op[row_count] = r_op;
    row_addr[row_count] = r_addr;
    row_data[row_count] = r_data;
    row_mask[row_count] = r_mask;
    row_exp[row_count] = r_exp;
    row_count++;
  endtask

  task automatic fill_table();
    // fresh memory reads zero
    add_row(LW,        12'h000, 32'h00000000, 4'h0, 32'h00000000);
    add_row(LW,        12'hFFC, 32'h00000000, 4'h0, 32'h00000000);
    // merging stores into one word
    add_row(SW,        12'h010, 32'h11223344, 4'h0, 32'h00000000);
    add_row(SH,        12'h012, 32'h0000BEEF, 4'h0, 32'h00000000);
    add_row(SB,        12'h011, 32'h000000A5, 4'h0, 32'h00000000);
    add_row(LW,        12'h010, 32'h00000000, 4'h0, 32'hBEEFA544);
    add_row(SM,        12'h010, 32'hCAFED00D, 4'h5, 32'h00000000);
    add_row(LW,        12'h013, 32'h00000000, 4'h0, 32'hBEFEA50D);
    // lane selection and extension
    add_row(SW,        12'h020, 32'h80F17F02, 4'h0, 32'h00000000);
    add_row(LB,        12'h020, 32'h00000000, 4'h0, 32'h00000002);
    add_row(LB,        12'h021, 32'h00000000, 4'h0, 32'h0000007F);
    add_row(LB,        12'h022, 32'h00000000, 4'h0, 32'hFFFFFFF1);
    add_row(LBU,       12'h023, 32'h00000000, 4'h0, 32'h00000080);
    add_row(LH,        12'h020, 32'h00000000, 4'h0, 32'h00007F02);
    add_row(LH,        12'h022, 32'h00000000, 4'h0, 32'hFFFF80F1);
    add_row(LHU,       12'h022, 32'h00000000, 4'h0, 32'h000080F1);
    add_row(LM,        12'h020, 32'h00000000, 4'hA, 32'h80007F00);
    // atomics chained on one word, each returns the previous result
    add_row(SW,        12'h030, 32'h00000010, 4'h0, 32'h00000000);
    add_row(AMOADD_W,  12'h030, 32'h00000005, 4'h0, 32'h00000010);
    add_row(AMOXOR_W,  12'h030, 32'h000000FF, 4'h0, 32'h00000015);
    add_row(AMOAND_W,  12'h030, 32'h0000000F, 4'h0, 32'h000000EA);
    add_row(AMOOR_W,   12'h030, 32'h00000030, 4'h0, 32'h0000000A);
    add_row(AMOSWAP_W, 12'h030, 32'hFFFFFFF0, 4'h0, 32'h0000003A);
    add_row(AMOMIN_W,  12'h030, 32'hFFFFFFFB, 4'h0, 32'hFFFFFFF0);
    add_row(AMOMAX_W,  12'h030, 32'h00000003, 4'h0, 32'hFFFFFFF0);
    add_row(AMOMINU_W, 12'h030, 32'hFFFFFFFF, 4'h0, 32'h00000003);
    add_row(AMOMAXU_W, 12'h030, 32'h80000000, 4'h0, 32'h00000003);
    add_row(AMOMIN_W,  12'h030, 32'h00000001, 4'h0, 32'h80000000);
    add_row(LW,        12'h030, 32'h00000000, 4'h0, 32'h80000000);
    // block 0x020..0x03F cleared, neighbours kept
    add_row(SW,        12'h040, 32'h5A5A5A5A, 4'h0, 32'h00000000);
    add_row(SW,        12'h03C, 32'h0F0F0F0F, 4'h0, 32'h00000000);
    add_row(AALLOCZ,   12'h034, 32'h00000000, 4'h0, 32'h00000000);
    add_row(LW,        12'h020, 32'h00000000, 4'h0, 32'h00000000);
    add_row(LW,        12'h03C, 32'h00000000, 4'h0, 32'h00000000);
    add_row(LW,        12'h030, 32'h00000000, 4'h0, 32'h00000000);
    add_row(LW,        12'h010, 32'h00000000, 4'h0, 32'hBEFEA50D);
    add_row(LW,        12'h040, 32'h00000000, 4'h0, 32'h5A5A5A5A);
  endtask

  // called 2 ns after an edge, returns 2 ns after the accepting edge
  task automatic send_request(input mem_opcode_e s_op, input logic [ADDR_WIDTH-1:0] s_addr,
      input logic [DATA_WIDTH-1:0] s_data, input logic [MASK_WIDTH-1:0] s_mask,
      input logic [DATA_WIDTH-1:0] s_exp, input logic s_use_exp);
    opcode_i = s_op;
    addr_i = s_addr;
    data_i = s_data;
    mask_i = s_mask;
    exp_data = s_exp;
    exp_v = s_use_exp;
    v_i = 1'b1;
    @(posedge clk_i);
    while (!ready_o) @(posedge clk_i);
    #2;
    v_i = 1'b0;
    exp_v = 1'b0;
    sent++;
  endtask

  initial begin
    reset_i = 1'b1;
    opcode_i = LW;
    addr_i = '0;
    data_i = '0;
    mask_i = '0;
    v_i = 1'b0;
    exp_data = '0;
    exp_v = 1'b0;
    seed = 52;
    sent = 0;
    row_count = 0;
    fill_table();
    repeat (RESET_CYCLES) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      send_request(row_op[r], row_addr[r], row_data[r], row_mask[r], row_exp[r], 1'b1);
    end
    for (int n = 0; n < NUM_RANDOM; n++) begin
      op = mem_opcode_e'($unsigned($random(seed)) % (int'(AALLOCZ) + 1));
      addr = ADDR_WIDTH'($unsigned($random(seed)) % 256);
      if (op == LH || op == LHU || op == SH) begin
        addr[0] = 1'b0;
      end
      data = $random(seed);
      mask = MASK_WIDTH'($random(seed));
      send_request(op, addr, data, mask, '0, 1'b0);
    end
    wait (resp_count >= sent);
    @(posedge clk_i);
    $display("%0d checks passed, %0d failed, %0d requests sent", pass_count, fail_count, sent);
    if (fail_count == 0 && pass_count == sent) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
source/mem_geom_pkg.sv
source/mem_op_pkg.sv
source/store_align.sv
source/load_align.sv
source/amo_alu.sv
source/mem_engine.sv
source/word_mem_top.sv
bench/shadow_checker.sv
bench/tb_word_mem.sv

// ==== source/amo_alu.sv ====
`timescale 1ns/1ps

module amo_alu
  import mem_geom_pkg::*;
  import mem_op_pkg::*;
(
  input  mem_opcode_e           opcode_i,
  input  logic [DATA_WIDTH-1:0] operand_i,
  input  logic [DATA_WIDTH-1:0] old_word_i,
  output logic [DATA_WIDTH-1:0] new_word_o
);

  logic signed_lt;
  logic unsigned_lt;

  // operand compared against the word in memory
  assign signed_lt   = $signed(operand_i) < $signed(old_word_i);
  assign unsigned_lt = operand_i < old_word_i;

  always_comb begin
    case (opcode_i)
      AMOSWAP_W: new_word_o = operand_i;
      AMOADD_W:  new_word_o = operand_i + old_word_i;
      AMOXOR_W:  new_word_o = operand_i ^ old_word_i;
      AMOAND_W:  new_word_o = operand_i & old_word_i;
      AMOOR_W:   new_word_o = operand_i | old_word_i;
      AMOMIN_W:  new_word_o = signed_lt ? operand_i : old_word_i;
      AMOMAX_W:  new_word_o = signed_lt ? old_word_i : operand_i;
      AMOMINU_W: new_word_o = unsigned_lt ? operand_i : old_word_i;
      AMOMAXU_W: new_word_o = unsigned_lt ? old_word_i : operand_i;
      default:   new_word_o = old_word_i;
    endcase
  end

endmodule

// ==== source/load_align.sv ====
`timescale 1ns/1ps

module load_align
  import mem_geom_pkg::*;
  import mem_op_pkg::*;
(
  input  mem_opcode_e           opcode_i,
  input  logic [1:0]            addr_lo_i,
  input  logic [MASK_WIDTH-1:0] mask_i,
  input  logic [DATA_WIDTH-1:0] rd_word_i,
  output logic [DATA_WIDTH-1:0] load_data_o
);

  logic [7:0]            byte_sel;
  logic [15:0]           half_sel;
  logic [DATA_WIDTH-1:0] bit_mask;

  // little-endian lane pick
  assign byte_sel = rd_word_i[8*addr_lo_i +: 8];
  assign half_sel = rd_word_i[16*addr_lo_i[1] +: 16];

  // byte enables widened to bit enables
  always_comb begin
    for (int b = 0; b < MASK_WIDTH; b++) begin
      bit_mask[8*b +: 8] = {8{mask_i[b]}};
    end
  end

  always_comb begin
    case (opcode_i)
      LW:      load_data_o = rd_word_i;
      LH:      load_data_o = {{16{half_sel[15]}}, half_sel};
      LB:      load_data_o = {{24{byte_sel[7]}}, byte_sel};
      LHU:     load_data_o = {16'b0, half_sel};
      LBU:     load_data_o = {24'b0, byte_sel};
      LM:      load_data_o = rd_word_i & bit_mask;
      default: load_data_o = '0;
    endcase
  end

endmodule

// ==== source/mem_engine.sv ====
`timescale 1ns/1ps

module mem_engine
  import mem_geom_pkg::*;
  import mem_op_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  mem_opcode_e           opcode_i,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  logic [DATA_WIDTH-1:0] data_i,
  input  logic [MASK_WIDTH-1:0] mask_i,
  input  logic                  v_i,
  input  logic [DATA_WIDTH-1:0] wr_data_i,
  input  logic [MASK_WIDTH-1:0] wr_mask_i,
  input  logic                  yumi_i,
  output logic                  ready_o,
  output logic                  v_o,
  output logic [DATA_WIDTH-1:0] data_o
);

  logic [DATA_WIDTH-1:0]      mem_q [MEM_WORDS];
  engine_state_e              state_q;
  logic                       init_q;
  logic                       resp_v_q;
  logic [DATA_WIDTH-1:0]      resp_data_q;
  logic [BLOCK_NUM_WIDTH-1:0] zero_blk_q;
  logic [BLOCK_IDX_WIDTH-1:0] zero_cnt_q;

  logic [WORD_ADDR_WIDTH-1:0] word_addr;
  logic [WORD_ADDR_WIDTH-1:0] zero_addr;
  logic [DATA_WIDTH-1:0]      rd_word;
  logic [DATA_WIDTH-1:0]      load_data;
  logic [DATA_WIDTH-1:0]      amo_word;
  logic [DATA_WIDTH-1:0]      resp_data;
  logic                       accept;
  logic                       is_load;
  logic                       is_store;
  logic                       is_amo;
  logic                       is_alloc;
  logic                       zero_last;

  assign word_addr = addr_i[ADDR_WIDTH-1:2];
  assign zero_addr = {zero_blk_q, zero_cnt_q};
  assign rd_word   = mem_q[word_addr];

  assign is_load  = LOAD_CLASS[opcode_i];
  assign is_store = STORE_CLASS[opcode_i];
  assign is_amo   = AMO_CLASS[opcode_i];
  assign is_alloc = (opcode_i == AALLOCZ);

  // init_q keeps ready low for the first cycle out of reset
  assign ready_o   = init_q && (state_q == ENG_IDLE) && (!resp_v_q || yumi_i);
  assign accept    = v_i && ready_o;
  assign zero_last = (zero_cnt_q == BLOCK_IDX_WIDTH'(BLOCK_WORDS - 1));

  load_align load_align_i (
    .opcode_i    (opcode_i),
    .addr_lo_i   (addr_i[1:0]),
    .mask_i      (mask_i),
    .rd_word_i   (rd_word),
    .load_data_o (load_data)
  );

  amo_alu amo_alu_i (
    .opcode_i   (opcode_i),
    .operand_i  (data_i),
    .old_word_i (rd_word),
    .new_word_o (amo_word)
  );

  // atomics answer with the old word, stores and AALLOCZ with zero
  assign resp_data = is_amo ? rd_word : (is_load ? load_data : '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= ENG_IDLE;
      init_q     <= 1'b0;
      resp_v_q   <= 1'b0;
      zero_cnt_q <= '0;
    end else begin
      init_q <= 1'b1;
      if (state_q == ENG_IDLE) begin
        if (accept && is_alloc) begin
          state_q    <= ENG_ZERO;
          zero_cnt_q <= '0;
        end
      end else begin
        zero_cnt_q <= zero_cnt_q + 1'b1;
        if (zero_last) begin
          state_q <= ENG_IDLE;
        end
      end
      if ((accept && !is_alloc) || (state_q == ENG_ZERO && zero_last)) begin
        resp_v_q <= 1'b1;
      end else if (yumi_i) begin
        resp_v_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_data_q <= resp_data;
    end
    if (accept && is_alloc) begin
      zero_blk_q <= word_addr[WORD_ADDR_WIDTH-1:BLOCK_IDX_WIDTH];
    end
  end

  // storage, written at the accept edge so the next request sees it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (state_q == ENG_ZERO) begin
      mem_q[zero_addr] <= '0;
    end else if (accept && is_amo) begin
      mem_q[word_addr] <= amo_word;
    end else if (accept && is_store) begin
      for (int b = 0; b < MASK_WIDTH; b++) begin
        if (wr_mask_i[b]) begin
          mem_q[word_addr][8*b +: 8] <= wr_data_i[8*b +: 8];
        end
      end
    end
  end

  assign v_o    = resp_v_q;
  assign data_o = resp_data_q;

  a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o);

  a_resp_holds: assert property (@(posedge clk_i) disable iff (reset_i)
    v_o && !yumi_i |=> v_o && $stable(data_o));

  a_no_accept_in_fill: assert property (@(posedge clk_i) disable iff (reset_i)
    accept && is_alloc |=> (!ready_o && !v_o) [*BLOCK_WORDS] ##1 v_o);

endmodule

// ==== source/mem_geom_pkg.sv ====
package mem_geom_pkg;

  // word geometry
  localparam int DATA_WIDTH = 32;
  localparam int MASK_WIDTH = DATA_WIDTH / 8;

  // byte address covers the whole array
  localparam int ADDR_WIDTH = 12;
  localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - 2;
  localparam int MEM_WORDS = 2 ** WORD_ADDR_WIDTH;

  // allocate-and-zero granule
  localparam int BLOCK_WORDS = 8;
  localparam int BLOCK_IDX_WIDTH = $clog2(BLOCK_WORDS);

  // block number part of a word index
  localparam int BLOCK_NUM_WIDTH = WORD_ADDR_WIDTH - BLOCK_IDX_WIDTH;

endpackage

// ==== source/mem_op_pkg.sv ====
package mem_op_pkg;

  localparam int OPCODE_WIDTH = 5;
  localparam int OPCODE_COUNT = 2 ** OPCODE_WIDTH;

  typedef enum logic [OPCODE_WIDTH-1:0] {
    LW, LH, LB, LHU, LBU, LM,
    SW, SH, SB, SM,
    AMOSWAP_W, AMOADD_W, AMOXOR_W, AMOAND_W, AMOOR_W,
    AMOMIN_W, AMOMAX_W, AMOMINU_W, AMOMAXU_W,
    AALLOCZ
  } mem_opcode_e;

  typedef enum logic {
    ENG_IDLE,
    ENG_ZERO
  } engine_state_e;

  // one bit per opcode value, indexed by the opcode
  localparam logic [OPCODE_COUNT-1:0] LOAD_CLASS =
    (OPCODE_COUNT'(1) << LW) | (OPCODE_COUNT'(1) << LH) | (OPCODE_COUNT'(1) << LB) |
    (OPCODE_COUNT'(1) << LHU) | (OPCODE_COUNT'(1) << LBU) | (OPCODE_COUNT'(1) << LM);

  localparam logic [OPCODE_COUNT-1:0] STORE_CLASS =
    (OPCODE_COUNT'(1) << SW) | (OPCODE_COUNT'(1) << SH) |
    (OPCODE_COUNT'(1) << SB) | (OPCODE_COUNT'(1) << SM);

  localparam logic [OPCODE_COUNT-1:0] AMO_CLASS =
    (OPCODE_COUNT'(1) << AMOSWAP_W) | (OPCODE_COUNT'(1) << AMOADD_W) |
    (OPCODE_COUNT'(1) << AMOXOR_W) | (OPCODE_COUNT'(1) << AMOAND_W) |
    (OPCODE_COUNT'(1) << AMOOR_W) | (OPCODE_COUNT'(1) << AMOMIN_W) |
    (OPCODE_COUNT'(1) << AMOMAX_W) | (OPCODE_COUNT'(1) << AMOMINU_W) |
    (OPCODE_COUNT'(1) << AMOMAXU_W);

endpackage

// ==== source/store_align.sv ====
`timescale 1ns/1ps

module store_align
  import mem_geom_pkg::*;
  import mem_op_pkg::*;
(
  input  mem_opcode_e           opcode_i,
  input  logic [1:0]            addr_lo_i,
  input  logic [DATA_WIDTH-1:0] data_i,
  input  logic [MASK_WIDTH-1:0] mask_i,
  output logic [DATA_WIDTH-1:0] wr_data_o,
  output logic [MASK_WIDTH-1:0] wr_mask_o
);

  always_comb begin
    case (opcode_i)
      SW: begin
        wr_data_o = data_i;
        wr_mask_o = '1;
      end
      SH: begin
        // upper half when address bit 1 is set
        wr_data_o = {2{data_i[15:0]}};
        wr_mask_o = addr_lo_i[1] ? 4'b1100 : 4'b0011;
      end
      SB: begin
        wr_data_o = {4{data_i[7:0]}};
        wr_mask_o = MASK_WIDTH'(1) << addr_lo_i;
      end
      SM: begin
        wr_data_o = data_i;
        wr_mask_o = mask_i;
      end
      default: begin
        wr_data_o = '0;
        wr_mask_o = '0;
      end
    endcase
  end

endmodule

// ==== source/word_mem_top.sv ====
`timescale 1ns/1ps

module word_mem_top
  import mem_geom_pkg::*;
  import mem_op_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  mem_opcode_e           opcode_i,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  logic [DATA_WIDTH-1:0] data_i,
  input  logic [MASK_WIDTH-1:0] mask_i,
  input  logic                  v_i,
  output logic                  ready_o,
  output logic [DATA_WIDTH-1:0] data_o,
  output logic                  v_o,
  input  logic                  yumi_i
);

  logic [DATA_WIDTH-1:0] wr_data;
  logic [MASK_WIDTH-1:0] wr_mask;

  store_align store_align_i (
    .opcode_i  (opcode_i),
    .addr_lo_i (addr_i[1:0]),
    .data_i    (data_i),
    .mask_i    (mask_i),
    .wr_data_o (wr_data),
    .wr_mask_o (wr_mask)
  );

  mem_engine mem_engine_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .opcode_i  (opcode_i),
    .addr_i    (addr_i),
    .data_i    (data_i),
    .mask_i    (mask_i),
    .v_i       (v_i),
    .wr_data_i (wr_data),
    .wr_mask_i (wr_mask),
    .yumi_i    (yumi_i),
    .ready_o   (ready_o),
    .v_o       (v_o),
    .data_o    (data_o)
  );

endmodule
